// File: all.f
verilog/alu_pkg.sv
verilog/alu_lane_if.sv
verilog/issue_dep_check.sv
verilog/operand_bypass.sv
verilog/alu_regfile.sv
verilog/alu_core.sv
verilog/alu_block.sv
verif/alu_block_asserts.sv
verif/alu_block_tb.sv

// File: Bender.yml
package:
  name: alu_block

sources:
  - files:
      - verilog/alu_pkg.sv
      - verilog/alu_lane_if.sv
      - verilog/issue_dep_check.sv
      - verilog/operand_bypass.sv
      - verilog/alu_regfile.sv
      - verilog/alu_core.sv
      - verilog/alu_block.sv
  - target: test
    files:
      - verif/alu_block_asserts.sv
      - verif/alu_block_tb.sv

// File: verif/alu_block_tb.sv
`timescale 1ns/100ps

module alu_block_tb import alu_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int RAND_GROUPS = 40;
  // Reset, preload, directed tests with drains, random groups, readback
  localparam int RUN_CYCLES  = 9 + 16 + 43 + 3 * RAND_GROUPS + 14;

  logic                        clk = 1'b0;
  logic                        rst_n, stall, do_stall, ld0_wen, ld1_wen;
  logic [NUM_LANES-1:0]        l_en, l_wen, do_split, wr_wen;
  reg_addr_t [NUM_LANES-1:0]   l_ra, l_rb, l_rt, wr_rt;
  alu_op_t [NUM_LANES-1:0]     l_op;
  reg_data_t [NUM_LANES-1:0]   wr_data;
  reg_addr_t                   ld0_rt, ld1_rt;
  reg_data_t                   ld0_data, ld1_data;
  reg_data_t                   ref_regs [NUM_REGS];   // Architectural register state
  logic [NUM_LANES-1:0]        s1_wen, s2_wen;
  alu_op_t                     s1_op [NUM_LANES];
  reg_addr_t                   s1_ra [NUM_LANES], s1_rb [NUM_LANES], s1_rt [NUM_LANES];
  reg_addr_t                   s2_rt [NUM_LANES];
  reg_data_t                   s2_data [NUM_LANES];
  int                          errors, checks, seed;

  alu_block UUT (
    .clk(clk), .rst_n(rst_n), .stall(stall), .do_stall(do_stall), .do_split(do_split),
    .alu0_en(l_en[0]), .alu0_ra(l_ra[0]), .alu0_rb(l_rb[0]), .alu0_rt(l_rt[0]),
    .alu0_wen(l_wen[0]), .alu0_op(l_op[0]),
    .alu1_en(l_en[1]), .alu1_ra(l_ra[1]), .alu1_rb(l_rb[1]), .alu1_rt(l_rt[1]),
    .alu1_wen(l_wen[1]), .alu1_op(l_op[1]),
    .alu2_en(l_en[2]), .alu2_ra(l_ra[2]), .alu2_rb(l_rb[2]), .alu2_rt(l_rt[2]),
    .alu2_wen(l_wen[2]), .alu2_op(l_op[2]),
    .ld0_rt(ld0_rt), .ld0_data(ld0_data), .ld0_wen(ld0_wen),
    .ld1_rt(ld1_rt), .ld1_data(ld1_data), .ld1_wen(ld1_wen),
    .wr0_rt(wr_rt[0]), .wr0_data(wr_data[0]), .wr0_wen(wr_wen[0]),
    .wr1_rt(wr_rt[1]), .wr1_data(wr_data[1]), .wr1_wen(wr_wen[1]),
    .wr2_rt(wr_rt[2]), .wr2_data(wr_data[2]), .wr2_wen(wr_wen[2])
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic reg_data_t alu_ref(input alu_op_t op, input reg_data_t a, input reg_data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SHL:  return a << b[5:0];
      OP_SHR:  return a >> b[5:0];
      default: return $signed(a) >>> b[5:0];   // OP_SAR
    endcase
  endfunction

  // Reference pipeline, compared before the edge takes effect
  always @(posedge clk) begin
    if (!rst_n) begin
      s1_wen = '0;
      s2_wen = '0;
    end else begin
      for (int k = 0; k < NUM_LANES; k++) begin
        checks++;
        assert (wr_wen[k] === (s2_wen[k] & ~stall)) else begin
          $display("MISMATCH at %0t: wr%0d_wen is %b", $time, k, wr_wen[k]);
          errors++;
        end
        if (wr_wen[k] && s2_wen[k]) begin
          assert (wr_rt[k] === s2_rt[k] && wr_data[k] === s2_data[k]) else begin
            $display("MISMATCH at %0t: wr%0d gives r%0d=%h, expected r%0d=%h", $time, k,
                     wr_rt[k], wr_data[k], s2_rt[k], s2_data[k]);
            errors++;
          end
        end
      end
      if (ld0_wen) ref_regs[ld0_rt] = ld0_data;
      if (ld1_wen) ref_regs[ld1_rt] = ld1_data;
      if (!stall) begin
        for (int k = 0; k < NUM_LANES; k++) begin
          if (s2_wen[k]) ref_regs[s2_rt[k]] = s2_data[k];   // Lane 2 lands last
        end
        // S1 operands equal the registers after this edge's writes
        for (int k = 0; k < NUM_LANES; k++) begin
          s2_wen[k]  = s1_wen[k];
          s2_rt[k]   = s1_rt[k];
          s2_data[k] = alu_ref(s1_op[k], ref_regs[s1_ra[k]], ref_regs[s1_rb[k]]);
          s1_wen[k]  = do_split[k] & l_wen[k];
          if (do_split[k]) begin
            s1_op[k] = l_op[k];
            s1_ra[k] = l_ra[k];
            s1_rb[k] = l_rb[k];
            s1_rt[k] = l_rt[k];
          end
        end
      end
    end
  end

  task automatic set_lane(input int k, input alu_op_t op, input reg_addr_t ra,
                          input reg_addr_t rb, input reg_addr_t rt);
    l_en[k]  = 1'b1;
    l_wen[k] = 1'b1;
    l_op[k]  = op;
    l_ra[k]  = ra;
    l_rb[k]  = rb;
    l_rt[k]  = rt;
  endtask

  // Re-present the group until every lane is taken; returns on a falling edge
  task automatic issue_group();
    logic [NUM_LANES-1:0] acc;
    while (l_en != '0) begin
      @(posedge clk);
      acc = do_split;
      @(negedge clk);
      l_en = l_en & ~acc;
    end
  endtask

  task automatic load(input logic w0, input reg_addr_t r0, input reg_data_t d0,
                      input logic w1, input reg_addr_t r1, input reg_data_t d1);
    ld0_wen  = w0;
    ld0_rt   = r0;
    ld0_data = d0;
    ld1_wen  = w1;
    ld1_rt   = r1;
    ld1_data = d1;
    @(negedge clk);
    ld0_wen = 1'b0;
    ld1_wen = 1'b0;
  endtask

  task automatic check_handshake(input logic [NUM_LANES-1:0] split, input logic stl);
    checks++;
    assert (do_split === split && do_stall === stl) else begin
      $display("MISMATCH at %0t: do_split=%b do_stall=%b, expected %b and %b", $time,
               do_split, do_stall, split, stl);
      errors++;
    end
  endtask

  task automatic check_wr0(input reg_addr_t rt, input reg_data_t data);
    checks++;
    assert (wr_wen[0] === 1'b1 && wr_rt[0] === rt && wr_data[0] === data) else begin
      $display("MISMATCH at %0t: wr0 gives r%0d=%h, expected r%0d=%h", $time,
               wr_rt[0], wr_data[0], rt, data);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    repeat (3) @(negedge clk);            // Drain S1 and S2
    $display("Test %-10s finished with %0d errors", name, errors - err_start);
  endtask

  task automatic test_opcodes();
    int e0;
    e0 = errors;
    for (int r = 0; r < NUM_REGS; r += 2) begin
      load(1'b1, reg_addr_t'(r), {$random(seed), $random(seed)},
           1'b1, reg_addr_t'(r + 1), {$random(seed), $random(seed)});
    end
    for (int op = 0; op < 8; op++) begin
      set_lane(0, alu_op_t'(op), reg_addr_t'(op), reg_addr_t'(op + 8), reg_addr_t'(op + 16));
      issue_group();
    end
    finish_test("opcodes", e0);
  endtask

  task automatic test_result_fwd();
    int e0;
    e0 = errors;
    set_lane(0, OP_ADD, 1, 2, 10);
    set_lane(1, OP_XOR, 3, 4, 10);
    set_lane(2, OP_SUB, 5, 6, 10);        // Lane 2 owns r10
    issue_group();
    set_lane(0, OP_OR, 10, 10, 11);
    set_lane(1, OP_ADD, 10, 1, 12);
    set_lane(2, OP_SHR, 10, 7, 13);
    issue_group();
    finish_test("result_fwd", e0);
  endtask

  task automatic test_split();
    int e0;
    e0 = errors;
    set_lane(0, OP_ADD, 1, 2, 14);
    set_lane(1, OP_XOR, 3, 4, 15);
    set_lane(2, OP_SUB, 14, 5, 16);
    @(posedge clk);
    check_handshake(3'b011, 1'b1);
    @(negedge clk);
    l_en = 3'b100;                        // Lane 2 alone, no longer dependent
    @(posedge clk);
    check_handshake(3'b100, 1'b0);
    @(negedge clk);
    l_en = '0;
    finish_test("split", e0);
  endtask

  task automatic test_load_fwd();
    int e0;
    reg_data_t d0, d1;
    e0 = errors;
    d0 = {$random(seed), $random(seed)};
    d1 = {$random(seed), $random(seed)};
    set_lane(0, OP_OR, 17, 17, 19);
    issue_group();
    load(1'b1, 17, d0, 1'b0, 0, '0);      // Same cycle as the S1 read
    check_wr0(19, d0);
    set_lane(0, OP_OR, 18, 18, 20);
    issue_group();
    load(1'b1, 18, d0, 1'b1, 18, d1);
    check_wr0(20, d1);
    finish_test("load_fwd", e0);
  endtask

  task automatic test_stall();
    int e0;
    e0 = errors;
    set_lane(0, OP_ADD, 1, 2, 21);
    set_lane(1, OP_SUB, 3, 4, 22);
    issue_group();
    set_lane(0, OP_XOR, 21, 5, 23);
    set_lane(2, OP_SHL, 6, 7, 24);
    issue_group();
    stall = 1'b1;
    set_lane(1, OP_OR, 23, 22, 25);
    repeat (4) begin
      @(posedge clk);
      check_handshake(3'b000, 1'b1);
    end
    @(negedge clk);
    stall = 1'b0;
    issue_group();
    finish_test("stall", e0);
  endtask

  task automatic test_random();
    int e0;
    logic [31:0] rnd;
    e0 = errors;
    for (int g = 0; g < RAND_GROUPS; g++) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        rnd      = $random(seed);
        l_op[k]  = rnd[2:0];
        l_ra[k]  = rnd[7:3];
        l_rb[k]  = rnd[12:8];
        l_rt[k]  = rnd[17:13];
        l_en[k]  = rnd[18];
        l_wen[k] = rnd[20:19] != 2'b00;
      end
      if (l_en == '0) @(negedge clk);
      else issue_group();
    end
    // Every register comes back out on a write port
    for (int r = 0; r < NUM_REGS; r += 3) begin
      for (int k = 0; k < NUM_LANES && r + k < NUM_REGS; k++) begin
        set_lane(k, OP_OR, reg_addr_t'(r + k), reg_addr_t'(r + k), reg_addr_t'(r + k));
      end
      issue_group();
    end
    finish_test("random", e0);
  endtask

  initial begin
    #((2 * RUN_CYCLES + 50) * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", 2 * RUN_CYCLES + 50);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed     = 32'h371a;
    errors   = 0;
    checks   = 0;
    rst_n    = 1'b1;
    stall    = 1'b0;
    l_en     = '0;
    l_wen    = '0;
    l_op     = '0;
    l_ra     = '0;
    l_rb     = '0;
    l_rt     = '0;
    ld0_wen  = 1'b0;
    ld0_rt   = '0;
    ld0_data = '0;
    ld1_wen  = 1'b0;
    ld1_rt   = '0;
    ld1_data = '0;
    #1 rst_n = 1'b0;                      // Clean falling edge for the async reset
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_opcodes();
    test_result_fwd();
    test_split();
    test_load_fwd();
    test_stall();
    test_random();
    errors += UUT.u_asserts.fail_count;   // Bound property failures
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule

// File: verif/alu_block_asserts.sv
`timescale 1ns/100ps

module alu_block_asserts import alu_pkg::*; (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 stall,
  input logic [NUM_LANES-1:0] do_split,
  input logic [NUM_LANES-1:0] lane_en,
  input logic [NUM_LANES-1:0] wr_wen
);

  int fail_count = 0;                       // Failed property count

  split_in_enables: assert property (@(posedge clk) disable iff (!rst_n)
      (do_split & ~lane_en) == '0)
    else begin
      $error("do_split accepts a lane that holds no operation");
      fail_count++;
    end

  no_split_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
      stall |-> do_split == '0)
    else begin
      $error("do_split is nonzero while stall is high");
      fail_count++;
    end

  wen_low_in_reset: assert property (@(posedge clk) !rst_n |-> wr_wen == '0)
    else begin
      $error("a write port is enabled during reset");
      fail_count++;
    end

  wen_low_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
      stall |-> wr_wen == '0)
    else begin
      $error("a write port is enabled while stall is high");
      fail_count++;
    end

  wen_known: assert property (@(posedge clk) !$isunknown(wr_wen))
    else begin
      $error("a write port enable is unknown");
      fail_count++;
    end

endmodule

bind alu_block alu_block_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .stall    (stall),
  .do_split (do_split),
  .lane_en  ({alu2_en, alu1_en, alu0_en}),
  .wr_wen   ({wr2_wen, wr1_wen, wr0_wen})
);

// File: verilog/alu_block.sv
`timescale 1ns/100ps

module alu_block import alu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  output logic                 do_stall,
  output logic [NUM_LANES-1:0] do_split,
  input  logic                 alu0_en,
  input  reg_addr_t            alu0_ra,
  input  reg_addr_t            alu0_rb,
  input  reg_addr_t            alu0_rt,
  input  logic                 alu0_wen,
  input  alu_op_t              alu0_op,
  input  logic                 alu1_en,
  input  reg_addr_t            alu1_ra,
  input  reg_addr_t            alu1_rb,
  input  reg_addr_t            alu1_rt,
  input  logic                 alu1_wen,
  input  alu_op_t              alu1_op,
  input  logic                 alu2_en,
  input  reg_addr_t            alu2_ra,
  input  reg_addr_t            alu2_rb,
  input  reg_addr_t            alu2_rt,
  input  logic                 alu2_wen,
  input  alu_op_t              alu2_op,
  input  reg_addr_t            ld0_rt,
  input  reg_data_t            ld0_data,
  input  logic                 ld0_wen,
  input  reg_addr_t            ld1_rt,
  input  reg_data_t            ld1_data,
  input  logic                 ld1_wen,
  output reg_addr_t            wr0_rt,
  output reg_data_t            wr0_data,
  output logic                 wr0_wen,
  output reg_addr_t            wr1_rt,
  output reg_data_t            wr1_data,
  output logic                 wr1_wen,
  output reg_addr_t            wr2_rt,
  output reg_data_t            wr2_data,
  output logic                 wr2_wen
);

  alu_lane_if lane0_if ();
  alu_lane_if lane1_if ();
  alu_lane_if lane2_if ();

  reg_addr_t            rd_addr_a  [NUM_LANES];
  reg_addr_t            rd_addr_b  [NUM_LANES];
  reg_data_t            rd_data_a  [NUM_LANES];
  reg_data_t            rd_data_b  [NUM_LANES];
  reg_data_t            opa        [NUM_LANES];
  reg_data_t            opb        [NUM_LANES];
  logic [NUM_LANES-1:0] res_valid;
  reg_addr_t            res_rt     [NUM_LANES];
  reg_data_t            res_data   [NUM_LANES];
  reg_addr_t            rf_wr_addr [NUM_WR];
  reg_data_t            rf_wr_data [NUM_WR];
  logic [NUM_WR-1:0]    rf_wr_en;

  assign lane0_if.en  = alu0_en;
  assign lane0_if.ra  = alu0_ra;
  assign lane0_if.rb  = alu0_rb;
  assign lane0_if.rt  = alu0_rt;
  assign lane0_if.wen = alu0_wen;
  assign lane0_if.op  = alu0_op;

  assign lane1_if.en  = alu1_en;
  assign lane1_if.ra  = alu1_ra;
  assign lane1_if.rb  = alu1_rb;
  assign lane1_if.rt  = alu1_rt;
  assign lane1_if.wen = alu1_wen;
  assign lane1_if.op  = alu1_op;

  assign lane2_if.en  = alu2_en;
  assign lane2_if.ra  = alu2_ra;
  assign lane2_if.rb  = alu2_rb;
  assign lane2_if.rt  = alu2_rt;
  assign lane2_if.wen = alu2_wen;
  assign lane2_if.op  = alu2_op;

  issue_dep_check u_dep (
    .stall    (stall),
    .lane0    (lane0_if),
    .lane1    (lane1_if),
    .lane2    (lane2_if),
    .do_split (do_split),
    .do_stall (do_stall)
  );

  operand_bypass u_bypass (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .do_split  (do_split),
    .lane0     (lane0_if),
    .lane1     (lane1_if),
    .lane2     (lane2_if),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .res_valid (res_valid),
    .res_rt    (res_rt),
    .res_data  (res_data),
    .ld0_rt    (ld0_rt),
    .ld0_data  (ld0_data),
    .ld0_wen   (ld0_wen),
    .ld1_rt    (ld1_rt),
    .ld1_data  (ld1_data),
    .ld1_wen   (ld1_wen),
    .opa       (opa),
    .opb       (opb)
  );

  // Write ports in priority order: lane 2, lane 1, lane 0, load 1, load 0
  assign rf_wr_addr = '{res_rt[2], res_rt[1], res_rt[0], ld1_rt, ld0_rt};
  assign rf_wr_data = '{res_data[2], res_data[1], res_data[0], ld1_data, ld0_data};
  assign rf_wr_en   = {ld0_wen, ld1_wen, res_valid[0], res_valid[1], res_valid[2]};

  alu_regfile u_regfile (
    .clk       (clk),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_addr   (rf_wr_addr),
    .wr_data   (rf_wr_data),
    .wr_en     (rf_wr_en)
  );

  alu_core u_core0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .accept    (do_split[0]),
    .lane      (lane0_if),
    .opa       (opa[0]),
    .opb       (opb[0]),
    .res_valid (res_valid[0]),
    .res_rt    (res_rt[0]),
    .res_data  (res_data[0])
  );

  alu_core u_core1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .accept    (do_split[1]),
    .lane      (lane1_if),
    .opa       (opa[1]),
    .opb       (opb[1]),
    .res_valid (res_valid[1]),
    .res_rt    (res_rt[1]),
    .res_data  (res_data[1])
  );

  alu_core u_core2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .accept    (do_split[2]),
    .lane      (lane2_if),
    .opa       (opa[2]),
    .opb       (opb[2]),
    .res_valid (res_valid[2]),
    .res_rt    (res_rt[2]),
    .res_data  (res_data[2])
  );

  assign wr0_rt   = res_rt[0];
  assign wr0_data = res_data[0];
  assign wr0_wen  = res_valid[0];
  assign wr1_rt   = res_rt[1];
  assign wr1_data = res_data[1];
  assign wr1_wen  = res_valid[1];
  assign wr2_rt   = res_rt[2];
  assign wr2_data = res_data[2];
  assign wr2_wen  = res_valid[2];

endmodule

// File: verilog/alu_core.sv
`timescale 1ns/100ps

module alu_core import alu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  input  logic      accept,
  alu_lane_if.sink  lane,
  input  reg_data_t opa,
  input  reg_data_t opb,
  output logic      res_valid,
  output reg_addr_t res_rt,
  output reg_data_t res_data
);

  logic      s1_wen;
  alu_op_t   s1_op;
  reg_addr_t s1_rt;
  logic      s2_wen;
  reg_addr_t s2_rt;
  reg_data_t s2_data;
  reg_data_t result;
  shamt_t    shamt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_wen <= 1'b0;
      s2_wen <= 1'b0;
    end else if (!stall) begin
      s1_wen <= accept & lane.en & lane.wen;  // Bubble when nothing accepted
      s2_wen <= s1_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if (accept) begin
        s1_op <= lane.op;
        s1_rt <= lane.rt;
      end
      s2_rt   <= s1_rt;
      s2_data <= result;
    end
  end

  assign shamt = opb[5:0];

  always_comb begin
    case (s1_op)
      OP_ADD:  result = opa + opb;
      OP_SUB:  result = opa - opb;
      OP_AND:  result = opa & opb;
      OP_OR:   result = opa | opb;
      OP_XOR:  result = opa ^ opb;
      OP_SHL:  result = opa << shamt;
      OP_SHR:  result = opa >> shamt;
      OP_SAR:  result = reg_data_t'($signed(opa) >>> shamt);
      default: result = '0;
    endcase
  end

  assign res_valid = s2_wen & ~stall;       // Held result reappears once stall drops
  assign res_rt    = s2_rt;
  assign res_data  = s2_data;

endmodule

// File: verilog/alu_regfile.sv
`timescale 1ns/100ps

module alu_regfile import alu_pkg::*; (
  input  logic              clk,
  input  reg_addr_t         rd_addr_a [NUM_LANES],
  input  reg_addr_t         rd_addr_b [NUM_LANES],
  output reg_data_t         rd_data_a [NUM_LANES],
  output reg_data_t         rd_data_b [NUM_LANES],
  input  reg_addr_t         wr_addr   [NUM_WR],
  input  reg_data_t         wr_data   [NUM_WR],
  input  logic [NUM_WR-1:0] wr_en                  // Port 0 has the highest priority
);

  reg_data_t mem [NUM_REGS];

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      rd_data_a[k] = mem[rd_addr_a[k]];
      rd_data_b[k] = mem[rd_addr_b[k]];
    end
  end

  // Walk from the lowest priority port so the highest one lands last
  always_ff @(posedge clk) begin
    for (int p = NUM_WR - 1; p >= 0; p--) begin
      if (wr_en[p]) begin
        mem[wr_addr[p]] <= wr_data[p];
      end
    end
  end

endmodule

// File: verilog/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass import alu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  input  logic [NUM_LANES-1:0] do_split,
  alu_lane_if.sink             lane0,
  alu_lane_if.sink             lane1,
  alu_lane_if.sink             lane2,
  output reg_addr_t            rd_addr_a [NUM_LANES],
  output reg_addr_t            rd_addr_b [NUM_LANES],
  input  reg_data_t            rd_data_a [NUM_LANES],
  input  reg_data_t            rd_data_b [NUM_LANES],
  input  logic [NUM_LANES-1:0] res_valid,
  input  reg_addr_t            res_rt    [NUM_LANES],
  input  reg_data_t            res_data  [NUM_LANES],
  input  reg_addr_t            ld0_rt,
  input  reg_data_t            ld0_data,
  input  logic                 ld0_wen,
  input  reg_addr_t            ld1_rt,
  input  reg_data_t            ld1_data,
  input  logic                 ld1_wen,
  output reg_data_t            opa       [NUM_LANES],
  output reg_data_t            opb       [NUM_LANES]
);

  reg_addr_t lane_ra [NUM_LANES];
  reg_addr_t lane_rb [NUM_LANES];

  assign lane_ra = '{lane0.ra, lane1.ra, lane2.ra};
  assign lane_rb = '{lane0.rb, lane1.rb, lane2.rb};

  // S1 source addresses double as the regfile read addresses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        rd_addr_a[k] <= '0;
        rd_addr_b[k] <= '0;
      end
    end else if (!stall) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        if (do_split[k]) begin
          rd_addr_a[k] <= lane_ra[k];
          rd_addr_b[k] <= lane_rb[k];
        end
      end
    end
  end

  // Later assignments win, so the newest source is applied last
  function automatic reg_data_t forward(input reg_addr_t addr, input reg_data_t rf_val);
    reg_data_t val;
    val = rf_val;
    if (ld0_wen && ld0_rt == addr) val = ld0_data;
    if (ld1_wen && ld1_rt == addr) val = ld1_data;
    for (int j = 0; j < NUM_LANES; j++) begin
      if (res_valid[j] && res_rt[j] == addr) val = res_data[j];  // Highest lane last
    end
    return val;
  endfunction

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      opa[k] = forward(rd_addr_a[k], rd_data_a[k]);
      opb[k] = forward(rd_addr_b[k], rd_data_b[k]);
    end
  end

endmodule

// File: verilog/issue_dep_check.sv
`timescale 1ns/100ps

module issue_dep_check import alu_pkg::*; (
  input  logic                 stall,
  alu_lane_if.sink             lane0,
  alu_lane_if.sink             lane1,
  alu_lane_if.sink             lane2,
  output logic [NUM_LANES-1:0] do_split,
  output logic                 do_stall
);

  logic [NUM_LANES-1:0] en;
  logic [NUM_LANES-1:0] dep;
  logic [NUM_LANES-1:0] blocked;

  // Earlier lane j writes a register that a later lane reads
  function automatic logic hits(input logic j_en, input logic j_wen, input reg_addr_t j_rt,
                                input reg_addr_t k_ra, input reg_addr_t k_rb);
    return j_en && j_wen && (j_rt == k_ra || j_rt == k_rb);
  endfunction

  assign en = {lane2.en, lane1.en, lane0.en};

  assign dep[0] = 1'b0;                     // Oldest lane never waits
  assign dep[1] = hits(lane0.en, lane0.wen, lane0.rt, lane1.ra, lane1.rb);
  assign dep[2] = hits(lane0.en, lane0.wen, lane0.rt, lane2.ra, lane2.rb) |
                  hits(lane1.en, lane1.wen, lane1.rt, lane2.ra, lane2.rb);

  // Once a dependent lane is found every younger lane waits too
  always_comb begin
    blocked[0] = en[0] & dep[0];
    for (int k = 1; k < NUM_LANES; k++) begin
      blocked[k] = blocked[k-1] | (en[k] & dep[k]);
    end
  end

  assign do_split = en & ~blocked & {NUM_LANES{~stall}};
  assign do_stall = stall | (|(en & ~do_split));

endmodule

// File: verilog/alu_lane_if.sv
`timescale 1ns/100ps

interface alu_lane_if import alu_pkg::*; ();

  logic      en;                            // Lane holds an operation
  reg_addr_t ra;
  reg_addr_t rb;
  reg_addr_t rt;
  logic      wen;                           // Operation writes rt
  alu_op_t   op;

  modport issuer (
    output en, ra, rb, rt, wen, op
  );

  modport sink (
    input en, ra, rb, rt, wen, op
  );

endinterface

// File: verilog/alu_pkg.sv
package alu_pkg;

  localparam int NUM_LANES = 3;             // Issue width
  localparam int NUM_REGS  = 32;
  localparam int NUM_LD    = 2;             // Load writeback ports
  localparam int NUM_WR    = NUM_LANES + NUM_LD;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [63:0] reg_data_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [5:0]  shamt_t;             // Low bits of operand B

  localparam alu_op_t OP_ADD = 3'd0;
  localparam alu_op_t OP_SUB = 3'd1;
  localparam alu_op_t OP_AND = 3'd2;
  localparam alu_op_t OP_OR  = 3'd3;
  localparam alu_op_t OP_XOR = 3'd4;
  localparam alu_op_t OP_SHL = 3'd5;        // Logical left
  localparam alu_op_t OP_SHR = 3'd6;        // Logical right
  localparam alu_op_t OP_SAR = 3'd7;        // Arithmetic right

endpackage
